// ==== bench/ethBusTb.sv ====
// testbench for the register access front end with chip model, reference and response compare
`timescale 1ns/100ps

module ethBusTb;
    import ethBusPkg::*;

    localparam int clkPeriod = 8;
    localparam int initCycles = resetAssertCycles + resetWaitCycles;
    localparam int totalCmds = 100;      // upper bound on commands issued below
    localparam int worstLatency = 40;    // cycles per command with rspReady stalls
    localparam int limitCycles = initCycles + totalCmds * worstLatency;

    logic        sysclk;
    logic        reset;
    logic        cmdValid;
    logic        cmdReady;
    logic        cmdDma;
    logic        cmdWrite;
    logic        cmdWord;
    logic [7:0]  cmdAddr;
    logic [15:0] cmdData;
    logic        rspValid;
    logic        rspReady;
    logic [15:0] rspData;
    logic        rspError;
    logic        initReq;
    logic        initAck;
    logic        ethRstn;
    logic        ethCmd;
    logic        ethRdn;
    logic        ethWrn;
    logic [15:0] sdOut;
    logic [15:0] sdIn;
    logic        sdOe;

    logic [15:0] stimLfsr = 16'd16651;
    logic [15:0] readyLfsr = 16'd16651;   // separate stream for rspReady
    logic [7:0]  regMirror [0:255];
    logic [15:0] dmaMirror [$];
    logic [16:0] expQueue [$];            // {data, error} in issue order
    logic        throttle = 1'b0;
    int          mismatches = 0;
    int          otherErrors = 0;
    int          responses = 0;
    int          issued = 0;

    ethBusTop ethBusTop_i (.*);

    kszChipModel chip (
        .ethRstn (ethRstn),
        .ethCmd  (ethCmd),
        .ethRdn  (ethRdn),
        .ethWrn  (ethWrn),
        .sdOut   (sdOut),
        .sdIn    (sdIn)
    );

    bind kszBusSequencer kszBus_properties busProps (
        .sysclk (sysclk),
        .reset  (reset),
        .ethRdn (ethRdn),
        .ethWrn (ethWrn),
        .sdOe   (sdOe)
    );

    // --------------------
    function automatic logic [15:0] galoisStep(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);   // x^16+x^14+x^13+x^11+1
    endfunction

    function automatic logic [15:0] randomBits(input int width);
        logic [15:0] value;
        value = 16'h0000;
        for (int i = 0; i < width; i++) begin
            stimLfsr = galoisStep(stimLfsr);
            value = {value[14:0], stimLfsr[0]};
        end
        return value;
    endfunction

    // expected {data, error}, mirror follows the lane rules of the chip
    function automatic logic [16:0] referenceRsp(input logic dma, input logic write,
                                                 input logic word, input logic [7:0] addr,
                                                 input logic [15:0] data);
        logic [15:0] value;
        logic        high;    // odd tails sit on the SD high byte
        value = 16'h0000;
        high = addr[0];
        if (dma) begin
            if (write)
                dmaMirror.push_back(data);
            else
                value = dmaMirror.pop_front();
        end else if (word && addr[0]) begin
            return {16'h0000, 1'b1};   // misaligned, nothing touched
        end else if (word) begin
            if (write) begin
                regMirror[addr] = data[7:0];
                regMirror[addr + 8'd1] = data[15:8];
            end else
                value = {regMirror[addr + 8'd1], regMirror[addr]};
        end else if (write)
            regMirror[addr] = high ? data[15:8] : data[7:0];
        else
            value = high ? {regMirror[addr], 8'h00} : {8'h00, regMirror[addr]};
        return {value, 1'b0};
    endfunction

    task automatic checkValue(input string what, input logic [31:0] got,
                              input logic [31:0] want);
        if (got !== want) begin
            mismatches++;
            $display("mismatch at %0t: %s, got %0h expected %0h", $time, what, got, want);
        end
    endtask

    // called right after a rising edge, returns on the transfer edge
    task automatic issueCmd(input logic dma, input logic write, input logic word,
                            input logic [7:0] addr, input logic [15:0] data);
        expQueue.push_back(referenceRsp(dma, write, word, addr, data));
        issued++;
        cmdValid <= 1'b1;
        cmdDma   <= dma;
        cmdWrite <= write;
        cmdWord  <= word;
        cmdAddr  <= addr;
        cmdData  <= data;
        @(negedge sysclk);
        while (!cmdReady)
            @(negedge sysclk);
        @(posedge sysclk);
    endtask

    // --------------------
    initial begin
        sysclk = 1'b0;
        forever #(clkPeriod / 2) sysclk = ~sysclk;
    end

    initial begin
        rspReady <= 1'b0;
        forever begin
            @(posedge sysclk);
            if (throttle) begin
                readyLfsr = galoisStep(readyLfsr);
                rspReady <= readyLfsr[0];
            end else
                rspReady <= 1'b1;
        end
    end

    // compare on every accepted response, sampled mid cycle
    initial begin
        logic [16:0] want;
        forever begin
            @(negedge sysclk);
            if (reset && rspValid && rspReady) begin
                responses++;
                if (expQueue.size() == 0) begin
                    otherErrors++;
                    $display("error at %0t: response with no command outstanding", $time);
                end else begin
                    want = expQueue.pop_front();
                    checkValue($sformatf("response %0d {data,error}", responses),
                               32'({rspData, rspError}), 32'(want));
                end
            end
        end
    end

    initial begin
        #(clkPeriod * limitCycles);
        $display("timeout: run did not finish within %0d cycles", limitCycles);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // --------------------
    // stimulus
    initial begin
        int          cycles;
        logic [7:0]  base;
        logic [15:0] rnd;
        logic [15:0] value;
        for (int i = 0; i < 256; i++)
            regMirror[i] = 8'h00;   // chip reset clears the registers
        reset    <= 1'b0;
        cmdValid <= 1'b0;
        cmdDma   <= 1'b0;
        cmdWrite <= 1'b0;
        cmdWord  <= 1'b0;
        cmdAddr  <= 8'h00;
        cmdData  <= 16'h0000;
        initAck  <= 1'b0;
        repeat (2) @(posedge sysclk);
        reset <= 1'b1;

        // initReq timing, host blocked meanwhile
        cycles = 0;
        while (initReq !== 1'b1 && cycles <= initCycles + 4) begin
            @(posedge sysclk);
            cycles++;
            @(negedge sysclk);
            checkValue("ethRstn during chip reset", 32'(ethRstn),
                       32'(cycles >= resetAssertCycles));
            if (initReq !== 1'b1) begin
                checkValue("cmdReady before initReq", 32'(cmdReady), 32'd0);
                checkValue("sdOe before initReq", 32'(sdOe), 32'd0);
            end
        end
        checkValue("cycles until initReq", 32'(cycles), 32'(initCycles));
        @(posedge sysclk);
        initAck <= 1'b1;
        @(posedge sysclk);
        initAck <= 1'b0;
        @(negedge sysclk);
        checkValue("initReq after initAck", 32'(initReq), 32'd0);
        checkValue("sdOe after init", 32'(sdOe), 32'd1);
        @(posedge sysclk);

        // byte write and read back at each tail
        for (int tail = 0; tail < 4; tail++) begin
            rnd = randomBits(6);
            base = {rnd[5:0], tail[1:0]};
            issueCmd(1'b0, 1'b1, 1'b0, base, randomBits(16));
            issueCmd(1'b0, 1'b0, 1'b0, base, 16'h0000);
        end

        // word round trips, neighbours filled first
        rnd = randomBits(6);
        base = {rnd[5:0], 2'd0};
        for (int k = 0; k < 4; k++)
            issueCmd(1'b0, 1'b1, 1'b0, {base[7:2], k[1:0]}, randomBits(16));
        issueCmd(1'b0, 1'b1, 1'b1, {base[7:2], 2'd2}, randomBits(16));
        issueCmd(1'b0, 1'b0, 1'b1, {base[7:2], 2'd2}, 16'h0000);
        issueCmd(1'b0, 1'b0, 1'b0, base, 16'h0000);
        issueCmd(1'b0, 1'b0, 1'b0, {base[7:2], 2'd1}, 16'h0000);
        issueCmd(1'b0, 1'b1, 1'b1, base, randomBits(16));
        issueCmd(1'b0, 1'b0, 1'b1, base, 16'h0000);
        issueCmd(1'b0, 1'b0, 1'b0, {base[7:2], 2'd2}, 16'h0000);
        issueCmd(1'b0, 1'b0, 1'b0, {base[7:2], 2'd3}, 16'h0000);

        // odd word offsets answer with error
        rnd = randomBits(7);
        base = {rnd[6:0], 1'b1};
        issueCmd(1'b0, 1'b1, 1'b0, base, randomBits(16));
        issueCmd(1'b0, 1'b1, 1'b1, base, randomBits(16));
        issueCmd(1'b0, 1'b0, 1'b1, base, 16'h0000);
        issueCmd(1'b0, 1'b0, 1'b0, base, 16'h0000);

        // DMA burst comes back first in, first out
        repeat (6) issueCmd(1'b1, 1'b1, 1'b0, 8'h00, randomBits(16));
        repeat (6) issueCmd(1'b1, 1'b0, 1'b0, 8'h00, 16'h0000);

        // random mix with rspReady stalls
        cmdValid <= 1'b0;
        @(negedge sysclk);
        throttle = 1'b1;
        @(posedge sysclk);
        for (int i = 0; i < 40; i++) begin
            rnd = randomBits(11);   // kind on 10:9, direction on 8, offset on 7:0
            value = randomBits(16);
            if (rnd[10:9] == 2'd3 && dmaMirror.size() != 0)
                issueCmd(1'b1, 1'b0, 1'b0, 8'h00, 16'h0000);
            else if (rnd[10])
                issueCmd(1'b1, 1'b1, 1'b0, 8'h00, value);   // also covers an empty queue
            else
                issueCmd(1'b0, rnd[8], rnd[9], rnd[7:0], value);
        end
        cmdValid <= 1'b0;

        while (expQueue.size() != 0)
            @(negedge sysclk);
        repeat (10) @(posedge sysclk);   // room for a stray response
        if (responses != issued) begin
            otherErrors++;
            $display("error: %0d commands issued but %0d responses seen", issued, responses);
        end
        $display("summary: %0d commands, %0d responses, %0d mismatches, %0d other errors",
                 issued, responses, mismatches, otherErrors);
        if (mismatches + otherErrors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== bench/kszBus_properties.sv ====
// concurrent checks on the chip bus strobes, bound into the bus sequencer
`timescale 1ns/100ps

module kszBus_properties (
    input logic sysclk,
    input logic reset,
    input logic ethRdn,
    input logic ethWrn,
    input logic sdOe
);
    import ethBusPkg::*;

    // read and write strobes never overlap
    strobesExclusive: assert property (@(posedge sysclk) disable iff (!reset)
        !(!ethRdn && !ethWrn))
        else $error("RDn and WRn low in the same cycle");

    // --------------------
    // WRn low for exactly strobeCycles before it rises
    wrnPulseWidth: assert property (@(posedge sysclk) disable iff (!reset)
        $rose(ethWrn) |-> (!$past(ethWrn, strobeCycles) && $past(ethWrn, strobeCycles + 1)))
        else $error("WRn low pulse not %0d cycles long", strobeCycles);

    // bus released whenever the chip drives it
    readReleasesBus: assert property (@(posedge sysclk) disable iff (!reset)
        !ethRdn |-> !sdOe)
        else $error("sdOe high while RDn is low");

endmodule

// ==== bench/kszChipModel.sv ====
// behavioral KSZ8851 style chip with a byte lane register file and a DMA word queue
`timescale 1ns/100ps

module kszChipModel (
    input  logic        ethRstn,
    input  logic        ethCmd,     // 1 address phase, 0 data phase
    input  logic        ethRdn,
    input  logic        ethWrn,
    input  logic [15:0] sdOut,
    output logic [15:0] sdIn
);
    logic [7:0]  regs [0:255];    // four byte lanes per dword
    logic [15:0] dmaQueue [$];
    logic [15:0] addrWord;        // byte enables on 15:12, offset on 7:0
    logic        addrLatched;     // address seen since the last data phase
    logic [15:0] readWord;
    logic        lastWrn;
    logic        lastRdn;

    // chip drives SD only while RDn is low
    assign sdIn = ethRdn ? 16'h0000 : readWord;

    // --------------------
    // all strobe edges in one process
    always @(ethWrn or ethRdn or ethRstn) begin
        if (ethRstn !== 1'b1) begin
            for (int i = 0; i < 256; i++)
                regs[i] = 8'h00;
            dmaQueue.delete();
            addrLatched = 1'b0;
            readWord    = 16'h0000;
        end else if (ethWrn && !lastWrn) begin
            if (ethCmd) begin
                addrWord    = sdOut;   // address taken on WRn rise
                addrLatched = 1'b1;
            end else if (addrLatched) begin
                for (int k = 0; k < 4; k++)
                    if (addrWord[12 + k])   // even lanes on SD low byte, odd on high
                        regs[{addrWord[7:2], k[1:0]}] = sdOut[(k % 2) * 8 +: 8];
                addrLatched = 1'b0;
            end else
                dmaQueue.push_back(sdOut);   // DMA write
        end else if (!ethRdn && lastRdn) begin
            readWord = 16'h0000;   // disabled lanes read zero
            if (addrLatched) begin
                for (int k = 0; k < 4; k++)
                    if (addrWord[12 + k])
                        readWord[(k % 2) * 8 +: 8] = readWord[(k % 2) * 8 +: 8]
                                                     | regs[{addrWord[7:2], k[1:0]}];
            end else if (dmaQueue.size() != 0)
                readWord = dmaQueue[0];
        end else if (ethRdn && !lastRdn) begin
            if (addrLatched)
                addrLatched = 1'b0;   // register data phase over
            else if (dmaQueue.size() != 0)
                void'(dmaQueue.pop_front());
        end
        lastWrn = ethWrn;
        lastRdn = ethRdn;
    end

endmodule

// ==== kszBus.f ====
source/ethBusPkg.sv
source/ethCmdPkg.sv
source/ethStageIf.sv
source/ethCmdIntake.sv
source/byteLaneEncoder.sv
source/kszBusSequencer.sv
source/ethBusTop.sv
bench/kszChipModel.sv
bench/kszBus_properties.sv
bench/ethBusTb.sv

// ==== runSim.sh ====
#!/bin/sh
# builds the ethBusTb simulation with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f kszBus.f --top-module ethBusTb -o ethBusSim || exit 1

simOut=$(./obj_dir/ethBusSim) || { echo "$simOut"; echo "simulation stopped with an error"; exit 1; }
echo "$simOut"

echo "$simOut" | grep -q "ALL TESTS PASSED" && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== source/byteLaneEncoder.sv ====
// second pipeline stage that turns a register offset and width into the chip address word
`timescale 1ns/100ps

module byteLaneEncoder (
    input  logic sysclk,
    input  logic reset,
    ethStageIf.receiver in,    // ethCmd_t from intake
    ethStageIf.sender   out    // ethBusCmd_t to the sequencer
);
    import ethBusPkg::*;

    logic primed;   // sequencer has been ready once

    // --------------------
    // chip sees the register space as 32-bit chunks with four byte lanes
    function automatic busAddr_t encodeAddr(logic [7:0] offset, logic isWord);
        busAddr_t   word;
        logic [1:0] tail;
        tail = offset[1:0];
        word.byteEn[0] = (tail == 2'd0);
        word.byteEn[1] = (!isWord && tail == 2'd1) || (isWord && tail == 2'd0);
        word.byteEn[2] = (tail == 2'd2);
        word.byteEn[3] = (!isWord && tail == 2'd3) || (isWord && tail == 2'd2);
        word.pad = '0;
        word.offset = offset;   // low bits kept as well
        return word;
    endfunction

    // same slot rule as intake
    assign in.ready = out.ready || (!out.valid && primed);

    always_ff @(posedge sysclk or negedge reset) begin
        if (!reset) begin
            out.valid <= 1'b0;
            primed    <= 1'b0;
        end else begin
            primed <= primed || out.ready;
            if (in.ready)
                out.valid <= in.valid;
        end
    end

    // --------------------
    always_ff @(posedge sysclk) begin
        if (in.valid && in.ready) begin
            out.payload.isDma      <= in.payload.isDma;
            out.payload.isWrite    <= in.payload.isWrite;
            out.payload.misaligned <= in.payload.misaligned;
            // computed for DMA too, sequencer ignores it there
            out.payload.addrWord   <= encodeAddr(in.payload.regAddr, in.payload.isWord);
            out.payload.data       <= in.payload.data;
        end
    end

endmodule

// ==== source/ethBusPkg.sv ====
// chip bus description with reset timing, address word layout and sequencer states

package ethBusPkg;

    // --------------------
    // timing, in sysclk cycles
    localparam int resetAssertCycles = 16;  // ethRstn held low this long
    localparam int resetWaitCycles = 32;    // settle time before initReq
    localparam int strobeCycles = 2;        // RDn / WRn low time, 2 or more
    localparam int countWidth = $clog2(resetAssertCycles + resetWaitCycles);

    localparam int busWidth = 16;           // SD lines

    // --------------------
    // address word as the chip expects it on SD during the address phase
    typedef struct packed {
        logic [3:0] byteEn;   // SD[15:12] lane enables of the 32-bit chunk
        logic [3:0] pad;      // zero on SD[11:8]
        logic [7:0] offset;   // register offset on SD[7:0]
    } busAddr_t;

    // --------------------
    typedef enum logic [3:0] {
        resetAssert,   // chip held in reset
        resetWait,     // chip released and warming up
        idle,
        addrStart,     // address on SD with ethCmd high
        addrHold,
        addrEnd,
        writeStart,
        writeHold,
        writeEnd,
        readStart,     // bus released and waiting for RDn
        readHold,
        readEnd,       // sdIn captured here
        respond        // response held until taken
    } seqState_t;

endpackage

// ==== source/ethBusTop.sv ====
// top level of the register access front end joining intake, lane encoder and bus sequencer
`timescale 1ns/100ps

module ethBusTop (
    input  logic sysclk,
    input  logic reset,

    // host command
    input  logic                                cmdValid,
    output logic                                cmdReady,
    input  logic                                cmdDma,
    input  logic                                cmdWrite,
    input  logic                                cmdWord,
    input  logic [ethCmdPkg::regAddrWidth-1:0] cmdAddr,
    input  logic [ethCmdPkg::dataWidth-1:0]    cmdData,

    // host response
    output logic                                rspValid,
    input  logic                                rspReady,
    output logic [ethCmdPkg::dataWidth-1:0]    rspData,
    output logic                                rspError,

    output logic                                initReq,
    input  logic                                initAck,

    // chip bus, SD split into out, in and enable
    output logic                                ethRstn,
    output logic                                ethCmd,
    output logic                                ethRdn,
    output logic                                ethWrn,
    output logic [ethBusPkg::busWidth-1:0]      sdOut,
    input  logic [ethBusPkg::busWidth-1:0]      sdIn,
    output logic                                sdOe
);
    import ethCmdPkg::*;

    ethStageIf #(.payloadType(ethCmd_t))    intakeToLane ();
    ethStageIf #(.payloadType(ethBusCmd_t)) laneToSeq ();

    // --------------------
    ethCmdIntake ethCmdIntake_i (
        .sysclk   (sysclk),
        .reset    (reset),
        .cmdValid (cmdValid),
        .cmdDma   (cmdDma),
        .cmdWrite (cmdWrite),
        .cmdWord  (cmdWord),
        .cmdAddr  (cmdAddr),
        .cmdData  (cmdData),
        .cmdReady (cmdReady),
        .out      (intakeToLane.sender)
    );

    byteLaneEncoder byteLaneEncoder_i (
        .sysclk (sysclk),
        .reset  (reset),
        .in     (intakeToLane.receiver),
        .out    (laneToSeq.sender)
    );

    kszBusSequencer kszBusSequencer_i (
        .sysclk   (sysclk),
        .reset    (reset),
        .in       (laneToSeq.receiver),
        .initReq  (initReq),
        .initAck  (initAck),
        .ethRstn  (ethRstn),
        .ethCmd   (ethCmd),
        .ethRdn   (ethRdn),
        .ethWrn   (ethWrn),
        .sdOut    (sdOut),
        .sdIn     (sdIn),
        .sdOe     (sdOe),
        .rspValid (rspValid),
        .rspData  (rspData),
        .rspError (rspError),
        .rspReady (rspReady)
    );

endmodule

// ==== source/ethCmdIntake.sv ====
// first pipeline stage that registers host commands and flags misaligned word accesses
`timescale 1ns/100ps

module ethCmdIntake (
    input  logic sysclk,
    input  logic reset,

    // host command port
    input  logic                                cmdValid,
    input  logic                                cmdDma,
    input  logic                                cmdWrite,
    input  logic                                cmdWord,
    input  logic [ethCmdPkg::regAddrWidth-1:0] cmdAddr,
    input  logic [ethCmdPkg::dataWidth-1:0]    cmdData,
    output logic                                cmdReady,

    ethStageIf.sender out    // to the lane encoder
);

    logic primed;   // downstream has shown ready at least once

    // slot free or draining this cycle
    // host stays blocked until the chip side comes up
    assign cmdReady = out.ready || (!out.valid && primed);

    always_ff @(posedge sysclk or negedge reset) begin
        if (!reset) begin
            out.valid <= 1'b0;
            primed    <= 1'b0;
        end else begin
            primed <= primed || out.ready;
            if (cmdReady)
                out.valid <= cmdValid;   // refill or go empty
        end
    end

    // payload slot, loaded only on a host transfer
    always_ff @(posedge sysclk) begin
        if (cmdValid && cmdReady) begin
            out.payload <= '{isDma:      cmdDma,
                             isWrite:    cmdWrite,
                             isWord:     cmdWord,
                             regAddr:    cmdAddr,
                             data:       cmdData,
                             // odd word offset straddles two registers
                             misaligned: cmdWord && !cmdDma && cmdAddr[0]};
        end
    end

endmodule

// ==== source/ethCmdPkg.sv ====
// host side description of commands and responses of the register access front end

package ethCmdPkg;

    localparam int dataWidth = 16;      // register word and DMA word
    localparam int regAddrWidth = 8;    // register offset 0x00 to 0xFF

    // access kind comes from the three flags
    // isDma low selects a register byte or word, isDma high a DMA word
    // isWrite picks the direction, isWord only matters for register access
    typedef struct packed {
        logic                    isDma;
        logic                    isWrite;
        logic                    isWord;
        logic [regAddrWidth-1:0] regAddr;
        logic [dataWidth-1:0]    data;        // write data, don't care on reads
        logic                    misaligned;  // set by intake
    } ethCmd_t;

    // command after lane encoding, as the sequencer takes it
    typedef struct packed {
        logic                 isDma;
        logic                 isWrite;
        logic                 misaligned;
        ethBusPkg::busAddr_t  addrWord;   // unused for DMA
        logic [dataWidth-1:0] data;
    } ethBusCmd_t;

    typedef struct packed {
        logic [dataWidth-1:0] data;   // read data, zero for writes and errors
        logic                 error;
    } ethRsp_t;

endpackage

// ==== source/ethStageIf.sv ====
// valid/ready handshake between pipeline stages carrying one payload of any type
`timescale 1ns/100ps

interface ethStageIf #(
    parameter type payloadType = logic
);

    // transfer on a rising edge with valid and ready both high
    logic       valid;     // sender holds this and payload until transfer
    logic       ready;     // receiver takes the payload this cycle
    payloadType payload;

    // --------------------
    modport sender (
        output valid,
        output payload,
        input  ready
    );

    modport receiver (
        input  valid,
        input  payload,
        output ready
    );

endinterface

// ==== source/kszBusSequencer.sv ====
// chip bus sequencer that runs the reset timing and the address, write and read strobe cycles
`timescale 1ns/100ps

module kszBusSequencer (
    input  logic sysclk,
    input  logic reset,
    ethStageIf.receiver in,     // ethBusCmd_t from the lane encoder

    output logic initReq,       // chip out of reset, host init wanted
    input  logic initAck,

    // chip bus
    output logic                              ethRstn,
    output logic                              ethCmd,   // 1 address, 0 data
    output logic                              ethRdn,
    output logic                              ethWrn,
    output logic [ethBusPkg::busWidth-1:0]    sdOut,
    input  logic [ethBusPkg::busWidth-1:0]    sdIn,
    output logic                              sdOe,     // drive SD when high

    // host response
    output logic                              rspValid,
    output logic [ethCmdPkg::dataWidth-1:0]  rspData,
    output logic                              rspError,
    input  logic                              rspReady
);
    import ethBusPkg::*;
    import ethCmdPkg::*;

    seqState_t             state;
    logic [countWidth-1:0] count;      // reset timer and strobe length
    ethBusCmd_t            cmd;        // command being run
    logic                  accept;
    logic                  holdDone;   // WRn low for strobeCycles
    logic                  readDone;   // readEnd still inside the RDn pulse

    assign in.ready = (state == idle);  // one command at a time
    assign accept   = in.valid && in.ready;
    assign holdDone = (count == countWidth'(strobeCycles - 1));
    assign readDone = (count == countWidth'(strobeCycles - 2));

    // --------------------
    // control path
    always_ff @(posedge sysclk or negedge reset) begin
        if (!reset) begin
            state    <= resetAssert;
            count    <= '0;
            initReq  <= 1'b0;
            ethRstn  <= 1'b0;
            ethCmd   <= 1'b0;
            ethRdn   <= 1'b1;
            ethWrn   <= 1'b1;
            sdOe     <= 1'b0;
            rspValid <= 1'b0;
        end else begin
            if (initAck)
                initReq <= 1'b0;
            case (state)
                resetAssert: begin
                    if (count == countWidth'(resetAssertCycles - 1)) begin
                        ethRstn <= 1'b1;   // release the chip
                        count   <= '0;
                        state   <= resetWait;
                    end else
                        count <= count + 1'b1;
                end
                resetWait: begin
                    if (count == countWidth'(resetWaitCycles - 1)) begin
                        initReq <= 1'b1;
                        sdOe    <= 1'b1;   // we own SD from here on
                        state   <= idle;
                    end else
                        count <= count + 1'b1;
                end
                idle: begin
                    if (accept) begin
                        count <= '0;
                        if (in.payload.misaligned) begin
                            rspValid <= 1'b1;   // no bus cycle at all
                            state    <= respond;
                        end else if (in.payload.isDma) begin
                            ethCmd <= 1'b0;     // DMA has no address phase
                            if (in.payload.isWrite)
                                state <= writeStart;
                            else begin
                                sdOe  <= 1'b0;
                                state <= readStart;
                            end
                        end else begin
                            ethCmd <= 1'b1;
                            state  <= addrStart;
                        end
                    end
                end
                addrStart: begin
                    ethWrn <= 1'b0;   // chip latches address on WRn rise
                    count  <= '0;
                    state  <= addrHold;
                end
                addrHold: begin
                    if (holdDone) begin
                        ethWrn <= 1'b1;
                        state  <= addrEnd;
                    end else
                        count <= count + 1'b1;
                end
                addrEnd: begin
                    ethCmd <= 1'b0;   // address held one cycle past WRn rise
                    count  <= '0;
                    if (cmd.isWrite)
                        state <= writeStart;
                    else begin
                        sdOe  <= 1'b0;
                        state <= readStart;
                    end
                end
                writeStart: begin
                    ethWrn <= 1'b0;
                    count  <= '0;
                    state  <= writeHold;
                end
                writeHold: begin
                    if (holdDone) begin
                        ethWrn <= 1'b1;
                        state  <= writeEnd;
                    end else
                        count <= count + 1'b1;
                end
                writeEnd: begin
                    rspValid <= 1'b1;   // data hold cycle
                    state    <= respond;
                end
                readStart: begin
                    ethRdn <= 1'b0;   // SD already released
                    count  <= '0;
                    state  <= readHold;
                end
                readHold: begin
                    if (readDone)
                        state <= readEnd;
                    else
                        count <= count + 1'b1;
                end
                readEnd: begin
                    ethRdn   <= 1'b1;
                    rspValid <= 1'b1;
                    state    <= respond;
                end
                respond: begin
                    if (rspReady) begin
                        rspValid <= 1'b0;
                        sdOe     <= 1'b1;   // take SD back
                        state    <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // --------------------
    // data path
    always_ff @(posedge sysclk) begin
        if (accept) begin
            cmd      <= in.payload;
            rspData  <= '0;                      // writes and errors answer zero
            rspError <= in.payload.misaligned;
            if (in.payload.isDma)
                sdOut <= in.payload.data;
            else
                sdOut <= in.payload.addrWord;
        end
        if (state == addrEnd)
            sdOut <= cmd.data;                   // data phase follows
        if (state == readEnd)
            rspData <= sdIn;                     // RDn still low here
    end

endmodule
